// ==== list.f ====
hdl/spmv_pkg.sv
hdl/pe_cmd_if.sv
hdl/mem_req_if.sv
hdl/req_fifo.sv
hdl/command_ring.sv
hdl/pe_regs.sv
hdl/req_arbiter.sv
hdl/mem_req_queue.sv
hdl/spmv_pe.sv
tb/tb_spmv_pe.sv

// ==== Bender.yml ====
package:
  name: spmv_pe

sources:
  - hdl/spmv_pkg.sv
  - hdl/pe_cmd_if.sv
  - hdl/mem_req_if.sv
  - hdl/req_fifo.sv
  - hdl/command_ring.sv
  - hdl/pe_regs.sv
  - hdl/req_arbiter.sv
  - hdl/mem_req_queue.sv
  - hdl/spmv_pe.sv
  - target: simulation
    files:
      - tb/tb_spmv_pe.sv

// ==== tb/tb_spmv_pe.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_spmv_pe;

    localparam int pe_id = 3;
    localparam int n_win = 12;
    localparam int n_res = 18;
    localparam int n_x = 40;
    localparam int n_mat = 40;
    // ring commands over all tests
    localparam int n_ring = 18;
    localparam int n_items = n_ring + n_res + 2 + n_x + n_mat;
    localparam int timeout_cycles = 40 * n_items + 2000;

    logic clk;
    logic rst;
    logic [63:0] op_in;
    logic [63:0] op_out;
    logic busy_in;
    logic busy_out;
    logic result_push;
    logic [63:0] result_val;
    logic result_stall;
    logic x_req_push;
    logic [47:0] x_req_addr;
    logic x_req_stall;
    logic mat_req_push;
    logic [47:0] mat_req_addr;
    logic [1:0] mat_req_tag;
    logic mat_req_stall;
    logic req_mem_ld;
    logic req_mem_st;
    logic [47:0] req_mem_addr;
    logic [63:0] req_mem_d_or_tag;
    logic req_mem_stall;

    logic [31:0] lfsr;
    // register and request model
    logic [47:0] y_addr_m;
    logic [47:0] y_end_m;
    logic [47:0] st_addr_q[$];
    logic [63:0] st_data_q[$];
    logic [47:0] x_q[$];
    logic [47:0] mat_q[$];
    logic [1:0] tag_q[$];
    int errors;
    int tests_run;
    int tests_failed;
    int test_err0;
    int cycles;

    spmv_pe #(.pe_id(pe_id), .src_depth(32), .out_depth(32)) spmv_pe_i (
        .clk(clk), .rst(rst), .op_in(op_in), .op_out(op_out),
        .busy_in(busy_in), .busy_out(busy_out),
        .result_push(result_push), .result_val(result_val), .result_stall(result_stall),
        .x_req_push(x_req_push), .x_req_addr(x_req_addr), .x_req_stall(x_req_stall),
        .mat_req_push(mat_req_push), .mat_req_addr(mat_req_addr),
        .mat_req_tag(mat_req_tag), .mat_req_stall(mat_req_stall),
        .req_mem_ld(req_mem_ld), .req_mem_st(req_mem_st), .req_mem_addr(req_mem_addr),
        .req_mem_d_or_tag(req_mem_d_or_tag), .req_mem_stall(req_mem_stall)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // galois lfsr stepped once per bit
    function automatic logic [63:0] rand_bits(input int n);
        logic [63:0] r;
        int i;
        r = '0;
        for (i = 0; i < n; i++) begin
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
            r = {r[62:0], lfsr[0]};
        end
        return r;
    endfunction

    function automatic logic [63:0] make_word(input logic [3:0] opc, input logic [7:0] pe,
                                              input logic [3:0] idx, input logic [47:0] val);
        return {val, idx, pe, opc};
    endfunction

    function automatic logic addressed(input logic [7:0] pe);
        return pe[7] || (pe[6:0] == 7'(pe_id));
    endfunction

    task automatic report_mismatch(input string name, input logic [63:0] got,
                                   input logic [63:0] exp);
        $display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
        errors++;
    endtask

    task automatic report_error(input string what);
        $display("Error at %0t: %s", $time, what);
        errors++;
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        if (errors == test_err0) begin
            $display("test %0d %s: ok", tests_run, name);
        end else begin
            tests_failed++;
            $display("test %0d %s: %0d errors", tests_run, name, errors - test_err0);
        end
        test_err0 = errors;
    endtask

    // word forwarded after 2 cycles, return word (or the nop behind it) after 3
    task automatic send_cmd(input logic [63:0] w, input logic has_ret, input logic [47:0] ret_val);
        logic [63:0] ret_word;
        ret_word = make_word(spmv_pkg::op_return, 8'(pe_id), w[15:12], ret_val);
        @(posedge clk);
        op_in <= w;
        @(posedge clk);
        op_in <= '0;
        @(posedge clk);
        @(negedge clk);
        if (op_out !== w) report_mismatch("op_out", op_out, w);
        @(negedge clk);
        if (has_ret) begin
            if (op_out !== ret_word) report_mismatch("op_out", op_out, ret_word);
        end else if (op_out !== 64'd0) begin
            report_mismatch("op_out", op_out, 64'd0);
        end
    endtask

    task automatic load_reg(input logic [7:0] pe, input logic [3:0] idx, input logic [47:0] val);
        send_cmd(make_word(spmv_pkg::op_ld, pe, idx, val), 1'b0, '0);
        if (addressed(pe) && idx == spmv_pkg::reg_y_addr) y_addr_m = val;
        if (addressed(pe) && idx == spmv_pkg::reg_y_end) y_end_m = val;
    endtask

    task automatic read_reg(input logic [7:0] pe, input logic [3:0] idx);
        logic hit;
        logic [47:0] v;
        hit = addressed(pe) && (idx == spmv_pkg::reg_y_addr || idx == spmv_pkg::reg_y_end);
        v = (idx == spmv_pkg::reg_y_end) ? y_end_m : y_addr_m;
        send_cmd(make_word(spmv_pkg::op_read, pe, idx, 48'(rand_bits(48))), hit, v);
    endtask

    task automatic push_results(input int n);
        int i;
        logic go;
        logic [63:0] v;
        i = 0;
        while (i < n) begin
            @(negedge clk);
            go = (rand_bits(1) != 0) && !result_stall;
            v = rand_bits(64);
            @(posedge clk);
            result_push <= go;
            result_val <= v;
            if (go) begin
                // outside the y window the result is dropped
                if (y_addr_m != y_end_m) begin
                    st_addr_q.push_back(y_addr_m);
                    st_data_q.push_back(v);
                    y_addr_m = y_addr_m + 48'(spmv_pkg::y_step);
                end
                i++;
            end
        end
        @(posedge clk);
        result_push <= 1'b0;
    endtask

    task automatic run_loads;
        int x_left;
        int mat_left;
        logic go_x;
        logic go_mat;
        logic stall;
        logic [47:0] xa;
        logic [47:0] ma;
        logic [1:0] mt;
        x_left = n_x;
        mat_left = n_mat;
        while (x_left > 0 || mat_left > 0) begin
            @(negedge clk);
            go_x = (rand_bits(1) != 0) && !x_req_stall && x_left > 0;
            go_mat = (rand_bits(1) != 0) && !mat_req_stall && mat_left > 0;
            stall = (rand_bits(1) != 0);
            // x addresses keep bit 47 clear, matrix addresses set it
            xa = 48'(rand_bits(47));
            ma = 48'(rand_bits(47)) | 48'h8000_0000_0000;
            mt = 2'(rand_bits(2));
            @(posedge clk);
            x_req_push <= go_x;
            x_req_addr <= xa;
            mat_req_push <= go_mat;
            mat_req_addr <= ma;
            mat_req_tag <= mt;
            req_mem_stall <= stall;
            if (go_x) begin
                x_q.push_back(xa);
                x_left--;
            end
            if (go_mat) begin
                mat_q.push_back(ma);
                tag_q.push_back(mt);
                mat_left--;
            end
        end
        @(posedge clk);
        x_req_push <= 1'b0;
        mat_req_push <= 1'b0;
        req_mem_stall <= 1'b0;
    endtask

    task automatic wait_drain(input int limit);
        int n;
        n = 0;
        while ((st_addr_q.size() + x_q.size() + mat_q.size()) != 0 && n < limit) begin
            @(posedge clk);
            n++;
        end
        if ((st_addr_q.size() + x_q.size() + mat_q.size()) != 0) begin
            report_error($sformatf("%0d requests never reached the memory port",
                                   st_addr_q.size() + x_q.size() + mat_q.size()));
        end
    endtask

    // memory port against the model queues
    always @(negedge clk) begin
        if (req_mem_st) begin
            if (st_addr_q.size() == 0) begin
                report_error("store request without a matching result");
            end else begin
                if (req_mem_addr !== st_addr_q[0])
                    report_mismatch("req_mem_addr", req_mem_addr, st_addr_q[0]);
                if (req_mem_d_or_tag !== st_data_q[0])
                    report_mismatch("req_mem_d_or_tag", req_mem_d_or_tag, st_data_q[0]);
                st_addr_q.delete(0);
                st_data_q.delete(0);
            end
        end
        if (req_mem_ld && req_mem_addr[47]) begin
            if (mat_q.size() == 0) begin
                report_error("matrix load request without a matching push");
            end else begin
                if (req_mem_addr !== mat_q[0])
                    report_mismatch("req_mem_addr", req_mem_addr, mat_q[0]);
                if (req_mem_d_or_tag !== {61'd0, tag_q[0], 1'b0})
                    report_mismatch("req_mem_d_or_tag", req_mem_d_or_tag,
                                    {61'd0, tag_q[0], 1'b0});
                mat_q.delete(0);
                tag_q.delete(0);
            end
        end else if (req_mem_ld) begin
            if (x_q.size() == 0) begin
                report_error("x load request without a matching push");
            end else begin
                if (req_mem_addr !== x_q[0])
                    report_mismatch("req_mem_addr", req_mem_addr, x_q[0]);
                if (req_mem_d_or_tag !== 64'd1)
                    report_mismatch("req_mem_d_or_tag", req_mem_d_or_tag, 64'd1);
                x_q.delete(0);
            end
        end
    end

    initial begin
        cycles = 0;
        while (cycles < timeout_cycles) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout after %0d cycles", cycles);
        $display("Result: FAILED");
        $finish;
    end

    initial begin : main
        logic [47:0] base;
        int n;
        rst = 1'b1;
        op_in = '0;
        busy_in = 1'b0;
        result_push = 1'b0;
        result_val = '0;
        x_req_push = 1'b0;
        x_req_addr = '0;
        mat_req_push = 1'b0;
        mat_req_addr = '0;
        mat_req_tag = '0;
        req_mem_stall = 1'b0;
        lfsr = 32'h652f_0b04;
        errors = 0;
        tests_run = 0;
        tests_failed = 0;
        test_err0 = 0;
        y_addr_m = '0;
        y_end_m = '0;
        repeat (8) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        if (op_out !== 64'd0) report_mismatch("op_out", op_out, 64'd0);
        if ({busy_out, req_mem_ld, req_mem_st, result_stall, x_req_stall, mat_req_stall} !== 6'd0)
            report_mismatch("busy_out,req_mem_ld,req_mem_st,stalls",
                            {busy_out, req_mem_ld, req_mem_st, result_stall, x_req_stall,
                             mat_req_stall}, 64'd0);
        finish_test("reset values");

        load_reg(8'd3, spmv_pkg::reg_y_addr, 48'(rand_bits(48)));
        load_reg(8'h80, spmv_pkg::reg_y_end, 48'(rand_bits(48)));
        // return word of another PE passes through
        send_cmd(make_word(spmv_pkg::op_return, 8'd5, 4'd1, 48'(rand_bits(48))), 1'b0, '0);
        read_reg(8'd3, spmv_pkg::reg_y_addr);
        read_reg(8'd3, spmv_pkg::reg_y_end);
        finish_test("load and read back");

        load_reg(8'd5, spmv_pkg::reg_y_addr, 48'(rand_bits(48)));
        read_reg(8'd5, spmv_pkg::reg_y_addr);
        read_reg(8'd3, spmv_pkg::reg_y_addr);
        read_reg(8'd3, 4'd7);
        finish_test("address match");

        base = {5'd0, 40'(rand_bits(40)), 3'd0};
        load_reg(8'd3, spmv_pkg::reg_y_addr, base);
        load_reg(8'd3, spmv_pkg::reg_y_end, base + 48'(spmv_pkg::y_step * n_win));
        push_results(n_res);
        wait_drain(40 * n_res + 200);
        repeat (30) @(negedge clk);
        read_reg(8'd3, spmv_pkg::reg_y_addr);
        finish_test("result stores in the y window");

        run_loads();
        wait_drain(40 * (n_x + n_mat) + 200);
        repeat (30) @(negedge clk);
        finish_test("loads under random stall");

        base = {5'd0, 40'(rand_bits(40)), 3'd0};
        load_reg(8'd3, spmv_pkg::reg_y_addr, base);
        load_reg(8'd3, spmv_pkg::reg_y_end, base + 48'(2 * spmv_pkg::y_step));
        send_cmd(make_word(spmv_pkg::op_steady, 8'd3, 4'd0, 48'd0), 1'b0, '0);
        @(negedge clk);
        if (busy_out !== 1'b1) report_mismatch("busy_out", busy_out, 64'd1);
        push_results(2);
        wait_drain(200);
        n = 0;
        while (busy_out && n < 40) begin
            @(negedge clk);
            n++;
        end
        if (busy_out) report_error("busy_out did not fall within 40 cycles of the drain");
        @(posedge clk);
        busy_in <= 1'b1;
        @(posedge clk);
        @(posedge clk);
        repeat (6) begin
            @(negedge clk);
            if (busy_out !== 1'b1) report_mismatch("busy_out", busy_out, 64'd1);
        end
        @(posedge clk);
        busy_in <= 1'b0;
        @(posedge clk);
        @(posedge clk);
        @(negedge clk);
        if (busy_out !== 1'b0) report_mismatch("busy_out", busy_out, 64'd0);
        send_cmd(make_word(spmv_pkg::op_rst, 8'd3, 4'd0, 48'd0), 1'b0, '0);
        y_addr_m = '0;
        y_end_m = '0;
        read_reg(8'd3, spmv_pkg::reg_y_addr);
        read_reg(8'd3, spmv_pkg::reg_y_end);
        finish_test("steady, busy and soft reset");

        $display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== hdl/spmv_pe.sv ====
`timescale 1ns/1ps
`default_nettype none

module spmv_pe #(
    parameter int pe_id = 0,
    parameter int src_depth = 32,
    parameter int out_depth = 32
) (
    input wire clk,
    input wire rst,
    input wire [spmv_pkg::op_w-1:0] op_in,
    output logic [spmv_pkg::op_w-1:0] op_out,
    input wire busy_in,
    output logic busy_out,
    input wire result_push,
    input wire [spmv_pkg::word_w-1:0] result_val,
    output logic result_stall,
    input wire x_req_push,
    input wire [spmv_pkg::addr_w-1:0] x_req_addr,
    output logic x_req_stall,
    input wire mat_req_push,
    input wire [spmv_pkg::addr_w-1:0] mat_req_addr,
    input wire [spmv_pkg::tag_w-1:0] mat_req_tag,
    output logic mat_req_stall,
    output logic req_mem_ld,
    output logic req_mem_st,
    output logic [spmv_pkg::addr_w-1:0] req_mem_addr,
    output logic [spmv_pkg::word_w-1:0] req_mem_d_or_tag,
    input wire req_mem_stall
);

    logic core_rst;
    logic status;
    logic [spmv_pkg::addr_w-1:0] y_addr;
    logic y_room;
    logic store_issued;
    logic q_empty;

    pe_cmd_if cmd_bus ();
    mem_req_if req_bus ();

    command_ring #(.pe_id(pe_id)) ring_i (
        .clk(clk), .rst(rst), .op_in(op_in), .op_out(op_out),
        .busy_in(busy_in), .busy_out(busy_out), .status(status),
        .core_rst(core_rst), .cmd(cmd_bus.ring)
    );

    pe_regs regs_i (
        .clk(clk), .core_rst(core_rst), .cmd(cmd_bus.regs),
        .store_issued(store_issued), .q_empty(q_empty),
        .y_addr(y_addr), .y_room(y_room), .status(status)
    );

    req_arbiter #(.src_depth(src_depth)) arb_i (
        .clk(clk), .core_rst(core_rst),
        .result_push(result_push), .result_val(result_val),
        .x_req_push(x_req_push), .x_req_addr(x_req_addr),
        .mat_req_push(mat_req_push), .mat_req_addr(mat_req_addr),
        .mat_req_tag(mat_req_tag), .result_stall(result_stall),
        .x_req_stall(x_req_stall), .mat_req_stall(mat_req_stall),
        .y_addr(y_addr), .y_room(y_room), .store_issued(store_issued),
        .req(req_bus.arb)
    );

    mem_req_queue #(.out_depth(out_depth)) queue_i (
        .clk(clk), .core_rst(core_rst), .req(req_bus.queue),
        .req_mem_ld(req_mem_ld), .req_mem_st(req_mem_st),
        .req_mem_addr(req_mem_addr), .req_mem_d_or_tag(req_mem_d_or_tag),
        .req_mem_stall(req_mem_stall), .q_empty(q_empty)
    );

endmodule

`default_nettype wire

// ==== hdl/mem_req_queue.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_req_queue #(
    parameter int out_depth = 32
) (
    input wire clk,
    input wire core_rst,
    mem_req_if.queue req,
    output logic req_mem_ld,
    output logic req_mem_st,
    output logic [spmv_pkg::addr_w-1:0] req_mem_addr,
    output logic [spmv_pkg::word_w-1:0] req_mem_d_or_tag,
    input wire req_mem_stall,
    output logic q_empty
);

    // entry is {d_or_tag, addr, st, ld}
    localparam int ent_w = spmv_pkg::word_w + spmv_pkg::addr_w + 2;

    logic [ent_w-1:0] q;
    logic stall_r;
    logic pop;

    req_fifo #(.width(ent_w), .depth(out_depth), .af_count(4)) out_fifo (
        .clk(clk), .core_rst(core_rst), .push(req.push), .pop(pop),
        .d({req.d_or_tag, req.addr, req.st, req.ld}), .q(q), .empty(q_empty),
        .almost_full(req.almost_full)
    );

    assign pop = !q_empty && !stall_r;

    always_ff @(posedge clk) begin
        if (core_rst) begin
            stall_r <= 1'b0;
            req_mem_ld <= 1'b0;
            req_mem_st <= 1'b0;
        end else begin
            stall_r <= req_mem_stall;
            req_mem_ld <= pop && q[0];
            req_mem_st <= pop && q[1];
        end
    end

    always_ff @(posedge clk) begin
        req_mem_addr <= q[spmv_pkg::addr_w+1:2];
        req_mem_d_or_tag <= q[ent_w-1:spmv_pkg::addr_w+2];
    end

endmodule

`default_nettype wire

// ==== hdl/req_arbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

module req_arbiter #(
    parameter int src_depth = 32
) (
    input wire clk,
    input wire core_rst,
    input wire result_push,
    input wire [spmv_pkg::word_w-1:0] result_val,
    input wire x_req_push,
    input wire [spmv_pkg::addr_w-1:0] x_req_addr,
    input wire mat_req_push,
    input wire [spmv_pkg::addr_w-1:0] mat_req_addr,
    input wire [spmv_pkg::tag_w-1:0] mat_req_tag,
    output logic result_stall,
    output logic x_req_stall,
    output logic mat_req_stall,
    input wire [spmv_pkg::addr_w-1:0] y_addr,
    input wire y_room,
    output logic store_issued,
    mem_req_if.arb req
);

    localparam int src_af = 8;
    localparam int mat_w = spmv_pkg::addr_w + spmv_pkg::tag_w;

    logic st_empty;
    logic x_empty;
    logic mat_empty;
    logic st_af;
    logic x_af;
    logic mat_af;
    logic [spmv_pkg::word_w-1:0] st_q;
    logic [spmv_pkg::addr_w-1:0] x_q;
    logic [mat_w-1:0] mat_q;
    logic pop_st;
    logic pop_x;
    logic pop_mat;
    // pop choice and payload one cycle before the build
    logic sel_st;
    logic sel_x;
    logic sel_mat;
    logic [spmv_pkg::word_w-1:0] st_r;
    logic [spmv_pkg::addr_w-1:0] x_r;
    logic [mat_w-1:0] mat_r;
    logic [spmv_pkg::addr_w-1:0] nxt_addr;
    spmv_pkg::mem_word_u nxt_word;

    req_fifo #(.width(spmv_pkg::word_w), .depth(src_depth), .af_count(src_af)) st_fifo (
        .clk(clk), .core_rst(core_rst), .push(result_push), .pop(pop_st),
        .d(result_val), .q(st_q), .empty(st_empty), .almost_full(st_af)
    );

    req_fifo #(.width(spmv_pkg::addr_w), .depth(src_depth), .af_count(src_af)) x_fifo (
        .clk(clk), .core_rst(core_rst), .push(x_req_push), .pop(pop_x),
        .d(x_req_addr), .q(x_q), .empty(x_empty), .almost_full(x_af)
    );

    req_fifo #(.width(mat_w), .depth(src_depth), .af_count(src_af)) mat_fifo (
        .clk(clk), .core_rst(core_rst), .push(mat_req_push), .pop(pop_mat),
        .d({mat_req_addr, mat_req_tag}), .q(mat_q), .empty(mat_empty),
        .almost_full(mat_af)
    );

    // fixed priority with stores first
    always_comb begin
        pop_st = 1'b0;
        pop_x = 1'b0;
        pop_mat = 1'b0;
        if (!req.almost_full) begin
            if (!st_empty) begin
                pop_st = 1'b1;
            end else if (!x_empty) begin
                pop_x = 1'b1;
            end else if (!mat_empty) begin
                pop_mat = 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (core_rst) begin
            result_stall <= 1'b0;
            x_req_stall <= 1'b0;
            mat_req_stall <= 1'b0;
            sel_st <= 1'b0;
            sel_x <= 1'b0;
            sel_mat <= 1'b0;
        end else begin
            result_stall <= st_af;
            x_req_stall <= x_af;
            mat_req_stall <= mat_af;
            sel_st <= pop_st;
            sel_x <= pop_x;
            sel_mat <= pop_mat;
        end
    end

    always_ff @(posedge clk) begin
        if (pop_st) begin
            st_r <= st_q;
        end
        if (pop_x) begin
            x_r <= x_q;
        end
        if (pop_mat) begin
            mat_r <= mat_q;
        end
    end

    // results outside the y window are dropped here
    assign store_issued = sel_st && y_room;

    always_comb begin
        nxt_addr = y_addr;
        nxt_word = '0;
        if (sel_st) begin
            nxt_word.data = st_r;
        end else if (sel_x) begin
            nxt_addr = x_r;
            nxt_word.ld.is_x = 1'b1;
        end else if (sel_mat) begin
            nxt_addr = mat_r[mat_w-1:spmv_pkg::tag_w];
            nxt_word.ld.tag = mat_r[spmv_pkg::tag_w-1:0];
        end
    end

    always_ff @(posedge clk) begin
        if (core_rst) begin
            req.push <= 1'b0;
            req.st <= 1'b0;
            req.ld <= 1'b0;
        end else begin
            req.push <= store_issued || sel_x || sel_mat;
            req.st <= store_issued;
            req.ld <= sel_x || sel_mat;
        end
    end

    always_ff @(posedge clk) begin
        req.addr <= nxt_addr;
        req.d_or_tag <= nxt_word;
    end

endmodule

`default_nettype wire

// ==== hdl/pe_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

module pe_regs (
    input wire clk,
    input wire core_rst,
    pe_cmd_if.regs cmd,
    input wire store_issued,
    input wire q_empty,
    output logic [spmv_pkg::addr_w-1:0] y_addr,
    output logic y_room,
    output logic status
);

    logic [spmv_pkg::addr_w-1:0] y_end;
    logic [spmv_pkg::idle_w-1:0] idle_cnt;
    logic steady;
    logic ld_y_addr;
    logic ld_y_end;

    assign ld_y_addr = cmd.cmd_ld && (cmd.cmd_idx == spmv_pkg::reg_y_addr);
    assign ld_y_end = cmd.cmd_ld && (cmd.cmd_idx == spmv_pkg::reg_y_end);

    // y window pointers
    always_ff @(posedge clk) begin
        if (core_rst) begin
            y_addr <= '0;
            y_end <= '0;
        end else begin
            // a load wins over a store in the same cycle
            if (ld_y_addr) begin
                y_addr <= cmd.cmd_val;
            end else if (store_issued) begin
                y_addr <= y_addr + spmv_pkg::addr_w'(spmv_pkg::y_step);
            end
            if (ld_y_end) begin
                y_end <= cmd.cmd_val;
            end
        end
    end

    assign y_room = (y_addr != y_end);

    // idle timeout saturates once the top bit is set
    always_ff @(posedge clk) begin
        if (core_rst) begin
            idle_cnt <= '0;
        end else if (y_room || !q_empty || cmd.cmd_steady) begin
            idle_cnt <= '0;
        end else if (!idle_cnt[spmv_pkg::idle_w-1]) begin
            idle_cnt <= idle_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (core_rst) begin
            steady <= 1'b0;
        end else if (cmd.cmd_steady) begin
            steady <= 1'b1;
        end else if (idle_cnt[spmv_pkg::idle_w-1]) begin
            steady <= 1'b0;
        end
    end

    assign status = steady;

    // register read, same cycle as the command
    assign cmd.rd_hit = (cmd.cmd_idx == spmv_pkg::reg_y_addr)
                     || (cmd.cmd_idx == spmv_pkg::reg_y_end);
    assign cmd.rd_val = (cmd.cmd_idx == spmv_pkg::reg_y_end) ? y_end : y_addr;

endmodule

`default_nettype wire

// ==== hdl/command_ring.sv ====
`timescale 1ns/1ps
`default_nettype none

module command_ring #(
    parameter int pe_id = 0
) (
    input wire clk,
    input wire rst,
    input wire [spmv_pkg::op_w-1:0] op_in,
    output logic [spmv_pkg::op_w-1:0] op_out,
    input wire busy_in,
    output logic busy_out,
    input wire status,
    output logic core_rst,
    pe_cmd_if.ring cmd
);

    localparam int pe_lsb = spmv_pkg::opc_w;
    localparam int idx_lsb = pe_lsb + spmv_pkg::pe_w;
    localparam int val_lsb = idx_lsb + spmv_pkg::idx_w;
    localparam logic [spmv_pkg::pe_w-1:0] my_id = pe_id[spmv_pkg::pe_w-1:0];

    logic [spmv_pkg::op_w-1:0] op_in_r;
    logic [spmv_pkg::op_w-1:0] op_r;
    logic [spmv_pkg::opc_w-1:0] opc;
    logic [spmv_pkg::pe_w-1:0] pe_f;
    logic match;
    logic rst_cmd;
    logic rd_ret;
    logic soft_rst_0;
    logic soft_rst_1;
    logic busy_in_r;

    assign opc = op_r[pe_lsb-1:0];
    assign pe_f = op_r[idx_lsb-1:pe_lsb];
    assign cmd.cmd_idx = op_r[val_lsb-1:idx_lsb];
    assign cmd.cmd_val = op_r[spmv_pkg::op_w-1:val_lsb];

    // broadcast or our own id
    assign match = pe_f[spmv_pkg::pe_w-1]
                || (pe_f[spmv_pkg::pe_w-2:0] == my_id[spmv_pkg::pe_w-2:0]);

    always_comb begin
        cmd.cmd_ld = 1'b0;
        cmd.cmd_steady = 1'b0;
        rst_cmd = 1'b0;
        rd_ret = 1'b0;
        if (match) begin
            case (opc)
                spmv_pkg::op_ld: cmd.cmd_ld = 1'b1;
                spmv_pkg::op_steady: cmd.cmd_steady = 1'b1;
                spmv_pkg::op_rst: rst_cmd = 1'b1;
                // unknown index gives no return
                spmv_pkg::op_read: rd_ret = cmd.rd_hit;
                // nop and passing return words are only forwarded
                spmv_pkg::op_nop, spmv_pkg::op_return: ;
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            op_in_r <= '0;
            op_r <= '0;
            op_out <= '0;
            busy_in_r <= 1'b0;
            busy_out <= 1'b0;
            soft_rst_0 <= 1'b0;
            soft_rst_1 <= 1'b0;
        end else begin
            op_in_r <= op_in;
            op_r <= op_in_r;
            // a read hit takes the slot of the word behind it
            if (rd_ret) begin
                op_out <= {cmd.rd_val, cmd.cmd_idx, my_id, spmv_pkg::op_return};
            end else begin
                op_out <= op_in_r;
            end
            busy_in_r <= busy_in;
            busy_out <= status || busy_in_r;
            soft_rst_0 <= rst_cmd;
            soft_rst_1 <= soft_rst_0;
        end
    end

    assign core_rst = rst || soft_rst_1;

endmodule

`default_nettype wire

// ==== hdl/req_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

// show-ahead fifo with q valid whenever empty is low
module req_fifo #(
    parameter int width = 64,
    parameter int depth = 32,
    parameter int af_count = 8
) (
    input wire clk,
    input wire core_rst,
    input wire push,
    input wire pop,
    input wire [width-1:0] d,
    output logic [width-1:0] q,
    output logic empty,
    output logic almost_full
);

    localparam int aw = (depth > 1) ? $clog2(depth) : 1;
    localparam int cw = $clog2(depth + 1);
    localparam logic [aw-1:0] last = aw'(depth - 1);
    localparam logic [cw-1:0] af_level = cw'(depth - af_count);

    logic [width-1:0] mem [depth];
    logic [aw-1:0] wr_ptr;
    logic [aw-1:0] rd_ptr;
    logic [cw-1:0] count;
    logic full;
    logic do_push;
    logic do_pop;

    assign full = (count == cw'(depth));
    assign empty = (count == '0);
    assign almost_full = (count >= af_level);
    assign do_push = push && !full;
    assign do_pop = pop && !empty;
    assign q = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= d;
        end
    end

    always_ff @(posedge clk) begin
        if (core_rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == last) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == last) ? '0 : rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: ;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== hdl/mem_req_if.sv ====
`timescale 1ns/1ps
`default_nettype none

// built memory requests on their way to the output queue
interface mem_req_if;
    logic push;
    logic ld;
    logic st;
    logic [spmv_pkg::addr_w-1:0] addr;
    spmv_pkg::mem_word_u d_or_tag;
    logic almost_full;

    modport arb (
        output push, ld, st, addr, d_or_tag,
        input almost_full
    );

    modport queue (
        input push, ld, st, addr, d_or_tag,
        output almost_full
    );
endinterface

`default_nettype wire

// ==== hdl/pe_cmd_if.sv ====
`timescale 1ns/1ps
`default_nettype none

// decoded command from the ring, read value back from the registers
interface pe_cmd_if;
    logic cmd_ld;
    logic cmd_steady;
    logic [spmv_pkg::idx_w-1:0] cmd_idx;
    logic [spmv_pkg::val_w-1:0] cmd_val;
    logic [spmv_pkg::val_w-1:0] rd_val;
    logic rd_hit;

    modport ring (
        output cmd_ld, cmd_steady, cmd_idx, cmd_val,
        input rd_val, rd_hit
    );

    modport regs (
        input cmd_ld, cmd_steady, cmd_idx, cmd_val,
        output rd_val, rd_hit
    );
endinterface

`default_nettype wire

// ==== hdl/spmv_pkg.sv ====
`default_nettype none

package spmv_pkg;

    // opcode word layout from low to high
    localparam int op_w = 64;
    localparam int opc_w = 4;
    // top bit of the pe field is the broadcast flag
    localparam int pe_w = 8;
    localparam int idx_w = 4;
    localparam int val_w = 48;

    localparam logic [opc_w-1:0] op_nop = 4'd0;
    localparam logic [opc_w-1:0] op_rst = 4'd1;
    localparam logic [opc_w-1:0] op_steady = 4'd2;
    localparam logic [opc_w-1:0] op_ld = 4'd3;
    localparam logic [opc_w-1:0] op_read = 4'd4;
    localparam logic [opc_w-1:0] op_return = 4'd5;

    // register indices
    localparam logic [idx_w-1:0] reg_y_addr = 4'd0;
    localparam logic [idx_w-1:0] reg_y_end = 4'd1;

    // memory request port
    localparam int addr_w = 48;
    localparam int word_w = 64;
    localparam int tag_w = 2;

    // one y entry is a 64-bit word
    localparam int y_step = 8;

    // top bit set after 32 idle cycles
    localparam int idle_w = 6;

    // data word of a store, or tag word of a load
    typedef union packed {
        logic [word_w-1:0] data;
        struct packed {
            logic [word_w-tag_w-2:0] pad;
            logic [tag_w-1:0] tag;
            logic is_x;
        } ld;
    } mem_word_u;

endpackage

`default_nettype wire
